// ==== vlog.f ====
verilog/dcache_pkg.sv
verilog/dcache_rd_arbiter.sv
verilog/dcache_bank_ctrl.sv
verilog/dcache_data_banks.sv
verilog/dcache_tag_array.sv
verilog/dcache_hit_select.sv
verilog/dcache_mem_top.sv
tb/dcache_mem_asserts.sv
tb/tb_dcache_mem.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the dcache memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_dcache_mem -f vlog.f -o tb_dcache_mem

# the simulation status is decided from the log below
./obj_dir/tb_dcache_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== tb/tb_dcache_mem.sv ====
// testbench for the dcache memory: reference model, directed tests, check task and watchdog
module tb_dcache_mem;
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  localparam int NUM_PORTS  = 3;
  localparam int CLK_PERIOD = 100;
  localparam int ACK_LIMIT  = 20;
  // reset, array init and the refill-read loop, plus a margin for the shorter tests
  localparam int TEST_CYCLES = 16 + 2 * NUM_SETS + 8 * (2 + 4 * 3) + 200;
  localparam tag_t TAG_FLIP  = tag_t'(1) << (TAG_WIDTH - 1);

  logic                     clk_i;
  logic                     rst_ni;
  logic [NUM_PORTS-1:0]     rd_req;
  logic [NUM_PORTS-1:0]     rd_tag_only;
  logic [NUM_PORTS-1:0]     rd_prio;
  rd_addr_t [NUM_PORTS-1:0] rd_addr;
  tag_t [NUM_PORTS-1:0]     rd_tag;
  logic [NUM_PORTS-1:0]     rd_ack;
  way_vec_t                 rd_vld_bits;
  way_vec_t                 rd_hit_oh;
  word_t                    rd_data;
  logic                     wr_cl_vld;
  refill_t                  refill;
  way_vec_t                 wr_req;
  word_wr_t                 word_wr;
  logic                     wr_ack;

  // reference model of the arrays and of the round-robin pointer
  tag_t        model_tag [NUM_WAYS][NUM_SETS];
  logic        model_vld [NUM_WAYS][NUM_SETS];
  word_t       model_data [NUM_WAYS][NUM_SETS][NUM_BANKS];
  int          rr_model;
  logic [31:0] rng_state;
  int          check_errors;
  int          other_errors;

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  dcache_mem_top #(
    .NumPorts (NUM_PORTS)
  ) u_dut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req),
    .rd_tag_only_i (rd_tag_only),
    .rd_prio_i     (rd_prio),
    .rd_addr_i     (rd_addr),
    .rd_tag_i      (rd_tag),
    .rd_ack_o      (rd_ack),
    .rd_vld_bits_o (rd_vld_bits),
    .rd_hit_oh_o   (rd_hit_oh),
    .rd_data_o     (rd_data),
    .wr_cl_vld_i   (wr_cl_vld),
    .refill_i      (refill),
    .wr_req_i      (wr_req),
    .word_wr_i     (word_wr),
    .wr_ack_o      (wr_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and model lookups
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t rand_word();
    return {rand32(), rand32()};
  endfunction

  function automatic tag_t make_tag(input int way);
    logic [31:0] r;
    r = rand32();
    // low bits carry the way, so the valid tags of one set never match each other
    return {r[TAG_WIDTH-3:0], 2'(way)};
  endfunction

  function automatic way_vec_t expected_hit(input set_idx_t idx, input tag_t tag);
    way_vec_t hit;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = model_vld[w][idx] && (model_tag[w][idx] == tag);
    end
    return hit;
  endfunction

  function automatic way_vec_t expected_vld(input set_idx_t idx);
    way_vec_t vld;
    for (int w = 0; w < NUM_WAYS; w++) begin
      vld[w] = model_vld[w][idx];
    end
    return vld;
  endfunction

  function automatic word_t expected_word(input set_idx_t idx, input bank_sel_t off,
                                          input way_vec_t hit);
    word_t word;
    word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit[w]) word = model_data[w][idx][off];
    end
    return word;
  endfunction

  // only enabled bytes are replaced
  function automatic word_t merge_word(input word_t old, input word_t data, input word_be_t be);
    word_t res;
    res = old;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (be[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // high prio requests mask the rest, then first requester at or after the pointer
  function automatic int expected_grant(input logic [NUM_PORTS-1:0] req,
                                        input logic [NUM_PORTS-1:0] prio, input int ptr);
    logic [NUM_PORTS-1:0] cand;
    int                   p;
    cand = ((req & prio) != '0) ? (req & prio) : req;
    for (int i = 0; i < NUM_PORTS; i++) begin
      p = (ptr + i) % NUM_PORTS;
      if (cand[p]) return p;
    end
    return -1;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      check_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // port drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_refill(input way_vec_t we, input set_idx_t idx, input tag_t tag,
                              input way_vec_t vld);
    line_t data;
    data      = {rand_word(), rand_word(), rand_word(), rand_word()};
    wr_cl_vld = 1'b1;
    refill    = '{we: we, tag: tag, idx: idx, data: data, be: '1, vld_bits: vld};
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (we[w]) begin
        model_tag[w][idx] = tag;
        model_vld[w][idx] = vld[w];
        for (int k = 0; k < NUM_BANKS; k++) begin
          model_data[w][idx][k] = data[k*WORD_WIDTH +: WORD_WIDTH];
        end
      end
    end
  endtask

  task automatic refill_line(input way_vec_t we, input set_idx_t idx, input tag_t tag,
                             input way_vec_t vld);
    @(negedge clk_i);
    start_refill(we, idx, tag, vld);
    @(negedge clk_i);
    wr_cl_vld = 1'b0;
  endtask

  task automatic read_port(input int p, input set_idx_t idx, input bank_sel_t off,
                           input tag_t tag, input logic tag_only, output way_vec_t vld,
                           output way_vec_t hit, output word_t data);
    int waited;
    waited = 0;
    @(negedge clk_i);
    rd_req[p]      = 1'b1;
    rd_addr[p]     = '{idx: idx, off: off};
    rd_tag_only[p] = tag_only;
    #1;
    while (!rd_ack[p] && waited < ACK_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (!rd_ack[p]) begin
      other_errors++;
      $display("ERROR: read port %0d got no acknowledge within %0d cycles", p, ACK_LIMIT);
    end
    rr_model = (p + 1) % NUM_PORTS;
    // tag follows one cycle after the address
    @(negedge clk_i);
    rd_req[p] = 1'b0;
    rd_tag[p] = tag;
    #1;
    vld  = rd_vld_bits;
    hit  = rd_hit_oh;
    data = rd_data;
  endtask

  task automatic check_read(input string name, input int p, input set_idx_t idx,
                            input bank_sel_t off, input tag_t tag, input logic tag_only);
    way_vec_t vld;
    way_vec_t hit;
    way_vec_t exp_hit;
    word_t    data;
    read_port(p, idx, off, tag, tag_only, vld, hit, data);
    exp_hit = expected_hit(idx, tag);
    check_value({name, " valid bits"}, 64'(expected_vld(idx)), 64'(vld));
    check_value({name, " hit"}, 64'(exp_hit), 64'(hit));
    if (!tag_only && exp_hit != '0) begin
      check_value({name, " data"}, expected_word(idx, off, exp_hit), data);
    end
  endtask

  task automatic write_word(input int w, input set_idx_t idx, input bank_sel_t off,
                            input word_t data, input word_be_t be);
    int waited;
    waited = 0;
    @(negedge clk_i);
    wr_req  = way_vec_t'(1 << w);
    word_wr = '{idx: idx, off: off, data: data, be: be};
    #1;
    while (!wr_ack && waited < ACK_LIMIT) begin
      @(negedge clk_i);
      #1;
      waited++;
    end
    if (wr_ack) begin
      model_data[w][idx][off] = merge_word(model_data[w][idx][off], data, be);
    end else begin
      other_errors++;
      $display("ERROR: word write to set %0d got no acknowledge", idx);
    end
    @(negedge clk_i);
    wr_req = '0;
  endtask

  // caller has driven the requests; checks one grant per cycle until all are served
  task automatic grant_all(input string name, input logic [NUM_PORTS-1:0] req,
                           input logic [NUM_PORTS-1:0] prio);
    logic [NUM_PORTS-1:0] pending;
    int                   exp;
    pending = req;
    while (pending != '0) begin
      #1;
      exp = expected_grant(pending, prio & pending, rr_model);
      check_value({name, " grant"}, 64'(NUM_PORTS'(1) << exp), 64'(rd_ack));
      rr_model     = (exp + 1) % NUM_PORTS;
      pending[exp] = 1'b0;
      @(negedge clk_i);
      rd_req[exp]  = 1'b0;
      rd_prio[exp] = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_refill_read();
    set_idx_t idx;
    int       w;
    tag_t     tag;
    for (int n = 0; n < 8; n++) begin
      idx = set_idx_t'(rand32());
      w   = int'(rand32() % NUM_WAYS);
      tag = make_tag(w);
      refill_line(way_vec_t'(1 << w), idx, tag, '1);
      for (int k = 0; k < NUM_BANKS; k++) begin
        check_read("refill_read", 0, idx, bank_sel_t'(k), tag, 1'b0);
      end
    end
  endtask

  task automatic test_miss_tag_only();
    set_idx_t idx;
    int       w;
    int       w2;
    tag_t     tag;
    tag_t     tag2;
    idx  = set_idx_t'(rand32());
    w    = int'(rand32() % NUM_WAYS);
    w2   = (w + 1) % NUM_WAYS;
    tag  = make_tag(w);
    tag2 = make_tag(w2);
    refill_line(way_vec_t'(1 << w), idx, tag, '1);
    check_read("miss_wrong_tag", 0, idx, 2'd0, tag ^ TAG_FLIP, 1'b0);
    refill_line(way_vec_t'(1 << w2), idx, tag2, '0);
    check_read("miss_invalid_way", 0, idx, 2'd1, tag2, 1'b0);
    check_read("tag_only_lookup", 1, idx, 2'd2, tag, 1'b1);
  endtask

  task automatic test_word_merge();
    set_idx_t  idx;
    bank_sel_t off;
    int        w;
    tag_t      tag;
    for (int n = 0; n < 4; n++) begin
      idx = set_idx_t'(rand32());
      off = bank_sel_t'(rand32());
      w   = int'(rand32() % NUM_WAYS);
      tag = make_tag(w);
      refill_line(way_vec_t'(1 << w), idx, tag, '1);
      write_word(w, idx, off, rand_word(), word_be_t'(rand32()));
      check_read("word_merge", 0, idx, off, tag, 1'b0);
    end
  endtask

  task automatic collide(input string name, input logic tag_only, input logic same_bank);
    set_idx_t  idx;
    bank_sel_t rd_off;
    bank_sel_t wr_off;
    int        w;
    tag_t      tag;
    word_t     wdata;
    word_be_t  wbe;
    word_t     exp_rd;
    logic      exp_ack;
    idx     = set_idx_t'(rand32());
    rd_off  = bank_sel_t'(rand32());
    wr_off  = same_bank ? rd_off : bank_sel_t'(rd_off + 2'd1);
    w       = int'(rand32() % NUM_WAYS);
    tag     = make_tag(w);
    wdata   = rand_word();
    wbe     = word_be_t'(rand32());
    // only a data read on the same bank refuses the write
    exp_ack = !same_bank || tag_only;
    refill_line(way_vec_t'(1 << w), idx, tag, '1);
    exp_rd = model_data[w][idx][rd_off];
    @(negedge clk_i);
    rd_req[0]      = 1'b1;
    rd_addr[0]     = '{idx: idx, off: rd_off};
    rd_tag_only[0] = tag_only;
    wr_req         = way_vec_t'(1 << w);
    word_wr        = '{idx: idx, off: wr_off, data: wdata, be: wbe};
    #1;
    check_value({name, " read ack"}, 64'(1), 64'(rd_ack));
    check_value({name, " write ack"}, 64'(exp_ack), 64'(wr_ack));
    rr_model = 1;
    if (exp_ack) begin
      model_data[w][idx][wr_off] = merge_word(model_data[w][idx][wr_off], wdata, wbe);
    end
    @(negedge clk_i);
    rd_req[0]      = 1'b0;
    rd_tag_only[0] = 1'b0;
    rd_tag[0]      = tag;
    if (exp_ack) wr_req = '0;
    #1;
    check_value({name, " hit"}, 64'(expected_hit(idx, tag)), 64'(rd_hit_oh));
    if (!tag_only) check_value({name, " read data"}, exp_rd, rd_data);
    if (!exp_ack) begin
      // the refused write retries in a cycle without a read
      check_value({name, " retry ack"}, 64'(1), 64'(wr_ack));
      model_data[w][idx][wr_off] = merge_word(model_data[w][idx][wr_off], wdata, wbe);
      @(negedge clk_i);
      wr_req = '0;
    end
    check_read({name, " readback"}, 0, idx, wr_off, tag, 1'b0);
  endtask

  task automatic run_grants(input string name, input logic [NUM_PORTS-1:0] prio);
    @(negedge clk_i);
    rd_addr     = '0;
    rd_tag_only = '1;
    rd_req      = '1;
    rd_prio     = prio;
    grant_all(name, '1, prio);
    rd_tag_only = '0;
  endtask

  task automatic test_refill_block();
    set_idx_t idx;
    idx = set_idx_t'(rand32());
    @(negedge clk_i);
    rd_addr     = '0;
    rd_tag_only = '1;
    rd_req      = 3'b011;
    start_refill(way_vec_t'(1), idx, make_tag(0), '1);
    #1;
    check_value("refill_block ack", 64'(0), 64'(rd_ack));
    @(negedge clk_i);
    wr_cl_vld = 1'b0;
    #1;
    check_value("refill_block hit after refill", 64'(0), 64'(rd_hit_oh));
    grant_all("refill_block release", 3'b011, 3'b000);
    rd_tag_only = '0;
  endtask

  initial begin : main
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    rd_req       = '0;
    rd_tag_only  = '0;
    rd_prio      = '0;
    rd_addr      = '0;
    rd_tag       = '0;
    wr_cl_vld    = 1'b0;
    refill       = '0;
    wr_req       = '0;
    word_wr      = '0;
    rr_model     = 0;
    rng_state    = 32'h513e_bfaf;
    check_errors = 0;
    other_errors = 0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("reset rd_ack", 64'(0), 64'(rd_ack));
    check_value("reset wr_ack", 64'(0), 64'(wr_ack));
    check_value("reset hit", 64'(0), 64'(rd_hit_oh));
    // arrays have no reset, give every set a known invalid line
    for (int s = 0; s < NUM_SETS; s++) begin
      refill_line('1, set_idx_t'(s), '0, '0);
    end
    test_refill_read();
    test_miss_tag_only();
    test_word_merge();
    collide("collision same bank", 1'b0, 1'b1);
    collide("collision other bank", 1'b0, 1'b0);
    collide("collision tag-only", 1'b1, 1'b1);
    run_grants("round robin", 3'b000);
    run_grants("round robin again", 3'b000);
    run_grants("priority port 2", 3'b100);
    run_grants("priority ports 0 and 1", 3'b011);
    test_refill_block();
    repeat (2) @(negedge clk_i);
    $display("errors: %0d check failures, %0d protocol failures", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired after %0d cycles, the tests did not finish",
             2 * TEST_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== tb/dcache_mem_asserts.sv ====
// concurrent assertions on the dcache memory top level bound into dcache_mem_top
module dcache_mem_asserts #(
  parameter int unsigned NumPorts = 3
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic [NumPorts-1:0]  rd_ack_i,
  input dcache_pkg::way_vec_t rd_hit_oh_i,
  input logic                 wr_ack_i,
  input logic                 wr_cl_vld_i,
  input dcache_pkg::way_vec_t wr_req_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // tags of one set are unique among valid ways
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_hit_oh_i))
    else $error("read hit vector has more than one way set");

  a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(rd_ack_i))
    else $error("more than one read port acknowledged in a cycle");

  // refill owns every bank for its cycle
  a_no_wr_during_refill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wr_ack_i && wr_cl_vld_i))
    else $error("word write acknowledged during a refill");

  a_wr_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_ack_i |-> $onehot(wr_req_i))
    else $error("acknowledged word write does not select exactly one way");

endmodule

bind dcache_mem_top dcache_mem_asserts #(
  .NumPorts (NumPorts)
) u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .rd_ack_i    (rd_ack_o),
  .rd_hit_oh_i (rd_hit_oh_o),
  .wr_ack_i    (wr_ack_o),
  .wr_cl_vld_i (wr_cl_vld_i),
  .wr_req_i    (wr_req_i)
);

// ==== verilog/dcache_mem_top.sv ====
// dcache memory top level: read arbiter, bank control, data banks, tag array, hit select
module dcache_mem_top #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // read ports
  input  logic [NumPorts-1:0]                  rd_req_i,
  input  logic [NumPorts-1:0]                  rd_tag_only_i,
  input  logic [NumPorts-1:0]                  rd_prio_i,
  input  dcache_pkg::rd_addr_t [NumPorts-1:0]  rd_addr_i,
  input  dcache_pkg::tag_t [NumPorts-1:0]      rd_tag_i,
  output logic [NumPorts-1:0]                  rd_ack_o,
  output dcache_pkg::way_vec_t                 rd_vld_bits_o,
  output dcache_pkg::way_vec_t                 rd_hit_oh_o,
  output dcache_pkg::word_t                    rd_data_o,
  // refill port
  input  logic                                 wr_cl_vld_i,
  input  dcache_pkg::refill_t                  refill_i,
  // word write port
  input  dcache_pkg::way_vec_t                 wr_req_i,
  input  dcache_pkg::word_wr_t                 word_wr_i,
  output logic                                 wr_ack_o
);
  import dcache_pkg::*;

  localparam int unsigned IdxW = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                                   rd_acked;
  logic [IdxW-1:0]                        gnt_idx;

  bank_vec_t                              bank_req;
  bank_vec_t                              bank_we;
  set_idx_t [NUM_BANKS-1:0]               bank_idx;
  word_be_t [NUM_BANKS-1:0][NUM_WAYS-1:0] bank_be;
  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]    bank_wdata;
  word_t [NUM_BANKS-1:0][NUM_WAYS-1:0]    bank_rdata;

  way_vec_t                               tag_req;
  logic                                   tag_we;
  set_idx_t                               tag_idx;
  tag_t [NUM_WAYS-1:0]                    tag_rdata;
  way_vec_t                               vld_bits;

  dcache_rd_arbiter #(
    .NumPorts (NumPorts)
  ) u_rd_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_req_i    (rd_req_i),
    .rd_prio_i   (rd_prio_i),
    .wr_cl_vld_i (wr_cl_vld_i),
    .rd_ack_o    (rd_ack_o),
    .rd_acked_o  (rd_acked),
    .gnt_idx_o   (gnt_idx)
  );

  dcache_bank_ctrl #(
    .NumPorts (NumPorts)
  ) u_bank_ctrl (
    .rd_addr_i     (rd_addr_i),
    .rd_tag_only_i (rd_tag_only_i),
    .rd_acked_i    (rd_acked),
    .gnt_idx_i     (gnt_idx),
    .wr_cl_vld_i   (wr_cl_vld_i),
    .refill_i      (refill_i),
    .wr_req_i      (wr_req_i),
    .word_wr_i     (word_wr_i),
    .bank_req_o    (bank_req),
    .bank_we_o     (bank_we),
    .bank_idx_o    (bank_idx),
    .bank_be_o     (bank_be),
    .bank_wdata_o  (bank_wdata),
    .tag_req_o     (tag_req),
    .tag_we_o      (tag_we),
    .tag_idx_o     (tag_idx),
    .wr_ack_o      (wr_ack_o)
  );

  dcache_data_banks u_data_banks (
    .clk_i        (clk_i),
    .bank_req_i   (bank_req),
    .bank_we_i    (bank_we),
    .bank_idx_i   (bank_idx),
    .bank_be_i    (bank_be),
    .bank_wdata_i (bank_wdata),
    .bank_rdata_o (bank_rdata)
  );

  dcache_tag_array u_tag_array (
    .clk_i       (clk_i),
    .tag_req_i   (tag_req),
    .tag_we_i    (tag_we),
    .tag_idx_i   (tag_idx),
    .wr_tag_i    (refill_i.tag),
    .wr_vld_i    (refill_i.vld_bits),
    .tag_rdata_o (tag_rdata),
    .vld_bits_o  (vld_bits)
  );

  dcache_hit_select #(
    .NumPorts (NumPorts)
  ) u_hit_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_acked_i    (rd_acked),
    .gnt_idx_i     (gnt_idx),
    .rd_addr_i     (rd_addr_i),
    .rd_tag_i      (rd_tag_i),
    .tag_rdata_i   (tag_rdata),
    .vld_bits_i    (vld_bits),
    .bank_rdata_i  (bank_rdata),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_hit_oh_o   (rd_hit_oh_o),
    .rd_data_o     (rd_data_o)
  );

endmodule

// ==== verilog/dcache_hit_select.sv ====
// lookup state registers, tag compare and hitting-way word readout
module dcache_hit_select #(
  parameter int unsigned  NumPorts = 3,
  localparam int unsigned IdxW     = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        rd_acked_i,
  input  logic [IdxW-1:0]                             gnt_idx_i,
  input  dcache_pkg::rd_addr_t [NumPorts-1:0]         rd_addr_i,
  input  dcache_pkg::tag_t [NumPorts-1:0]             rd_tag_i,
  input  dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0] tag_rdata_i,
  input  dcache_pkg::way_vec_t                        vld_bits_i,
  input  dcache_pkg::word_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_rdata_i,
  output dcache_pkg::way_vec_t                        rd_vld_bits_o,
  output dcache_pkg::way_vec_t                        rd_hit_oh_o,
  output dcache_pkg::word_t                           rd_data_o
);
  import dcache_pkg::*;

  typedef struct packed {
    logic            cmp_en;
    logic [IdxW-1:0] port;
    bank_sel_t       off;
  } lookup_t;

  lookup_t              lkup_d;
  lookup_t              lkup_q;
  tag_t                 rd_tag;
  word_t [NUM_WAYS-1:0] way_words;

  // compare stays off after a refill since no grant is given then
  assign lkup_d.cmp_en = rd_acked_i;
  assign lkup_d.port   = gnt_idx_i;
  assign lkup_d.off    = rd_addr_i[gnt_idx_i].off;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lookup
    if (!rst_ni) begin
      lkup_q <= '0;
    end else begin
      lkup_q <= lkup_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare and readout
  ////////////////////////////////////////////////////////////////////////////

  // tag arrives one cycle after the address
  assign rd_tag        = rd_tag_i[lkup_q.port];
  assign rd_vld_bits_o = vld_bits_i;

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way_cmp
    assign rd_hit_oh_o[i] = lkup_q.cmp_en & vld_bits_i[i] & (tag_rdata_i[i] == rd_tag);
    assign way_words[i]   = bank_rdata_i[lkup_q.off][i];
  end

  // or-reduction over the one-hot hit vector selects the way
  always_comb begin : p_rd_mux
    rd_data_o = '0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (rd_hit_oh_o[i]) begin
        rd_data_o = rd_data_o | way_words[i];
      end
    end
  end

endmodule

// ==== verilog/dcache_tag_array.sv ====
// per-way tag and valid bit SRAM
module dcache_tag_array (
  input  logic                                         clk_i,
  input  dcache_pkg::way_vec_t                         tag_req_i,
  input  logic                                         tag_we_i,
  input  dcache_pkg::set_idx_t                         tag_idx_i,
  input  dcache_pkg::tag_t                             wr_tag_i,
  input  dcache_pkg::way_vec_t                         wr_vld_i,
  output dcache_pkg::tag_t [dcache_pkg::NUM_WAYS-1:0]  tag_rdata_o,
  output dcache_pkg::way_vec_t                         vld_bits_o
);
  import dcache_pkg::*;

  typedef struct packed {
    logic vld;
    tag_t tag;
  } tag_entry_t;

  for (genvar i = 0; i < NUM_WAYS; i++) begin : gen_way
    tag_entry_t mem_q [NUM_SETS];
    tag_entry_t rdata_q;

    // unrequested ways keep both contents and output
    always_ff @(posedge clk_i) begin : p_sram
      if (tag_req_i[i]) begin
        if (tag_we_i) begin
          mem_q[tag_idx_i] <= '{vld: wr_vld_i[i], tag: wr_tag_i};
        end else begin
          rdata_q <= mem_q[tag_idx_i];
        end
      end
    end

    assign tag_rdata_o[i] = rdata_q.tag;
    assign vld_bits_o[i]  = rdata_q.vld;
  end

endmodule

// ==== verilog/dcache_data_banks.sv ====
// banked data SRAM, one bank per word offset, per-way byte-enable writes
module dcache_data_banks (
  input  logic                                               clk_i,
  input  dcache_pkg::bank_vec_t                              bank_req_i,
  input  dcache_pkg::bank_vec_t                              bank_we_i,
  input  dcache_pkg::set_idx_t [dcache_pkg::NUM_BANKS-1:0]   bank_idx_i,
  input  dcache_pkg::word_be_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_be_i,
  input  dcache_pkg::word_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_wdata_i,
  output dcache_pkg::word_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_rdata_o
);
  import dcache_pkg::*;

  // each entry holds the same word offset of all ways
  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    word_t [NUM_WAYS-1:0] mem_q [NUM_SETS];
    word_t [NUM_WAYS-1:0] rdata_q;

    always_ff @(posedge clk_i) begin : p_sram
      if (bank_req_i[k]) begin
        if (bank_we_i[k]) begin
          for (int j = 0; j < NUM_WAYS; j++) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
              if (bank_be_i[k][j][b]) begin
                mem_q[bank_idx_i[k]][j][8*b +: 8] <= bank_wdata_i[k][j][8*b +: 8];
              end
            end
          end
        end else begin
          rdata_q <= mem_q[bank_idx_i[k]];
        end
      end
    end

    // read data holds until the next read of this bank
    assign bank_rdata_o[k] = rdata_q;
  end

endmodule

// ==== verilog/dcache_bank_ctrl.sv ====
// bank and tag request steering, byte enables and word-write acknowledge
module dcache_bank_ctrl #(
  parameter int unsigned  NumPorts = 3,
  localparam int unsigned IdxW     = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  dcache_pkg::rd_addr_t [NumPorts-1:0] rd_addr_i,
  input  logic [NumPorts-1:0]                 rd_tag_only_i,
  input  logic                                rd_acked_i,
  input  logic [IdxW-1:0]                     gnt_idx_i,
  input  logic                                wr_cl_vld_i,
  input  dcache_pkg::refill_t                 refill_i,
  input  dcache_pkg::way_vec_t                wr_req_i,
  input  dcache_pkg::word_wr_t                word_wr_i,
  output dcache_pkg::bank_vec_t               bank_req_o,
  output dcache_pkg::bank_vec_t               bank_we_o,
  output dcache_pkg::set_idx_t [dcache_pkg::NUM_BANKS-1:0] bank_idx_o,
  output dcache_pkg::word_be_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_be_o,
  output dcache_pkg::word_t [dcache_pkg::NUM_BANKS-1:0][dcache_pkg::NUM_WAYS-1:0] bank_wdata_o,
  output dcache_pkg::way_vec_t                tag_req_o,
  output logic                                tag_we_o,
  output dcache_pkg::set_idx_t                tag_idx_o,
  output logic                                wr_ack_o
);
  import dcache_pkg::*;

  rd_addr_t gnt_addr;
  logic     rd_data;
  logic     bank_busy;

  assign gnt_addr = rd_addr_i[gnt_idx_i];
  // tag-only lookups leave the data banks free
  assign rd_data  = rd_acked_i & ~rd_tag_only_i[gnt_idx_i];

  // word write loses only against a data read on its own bank
  assign bank_busy = rd_data & (gnt_addr.off == word_wr_i.off);
  assign wr_ack_o  = (|wr_req_i) & ~wr_cl_vld_i & ~bank_busy;

  ////////////////////////////////////////////////////////////////////////////
  // per-bank, per-way write data and byte enables
  ////////////////////////////////////////////////////////////////////////////

  for (genvar k = 0; k < NUM_BANKS; k++) begin : gen_bank
    for (genvar j = 0; j < NUM_WAYS; j++) begin : gen_way
      logic cl_wr;
      logic word_wr;

      assign cl_wr   = wr_cl_vld_i & refill_i.we[j];
      assign word_wr = wr_req_i[j] & wr_ack_o & (word_wr_i.off == bank_sel_t'(k));

      assign bank_be_o[k][j] = cl_wr   ? refill_i.be[k*WORD_BYTES +: WORD_BYTES] :
                               word_wr ? word_wr_i.be : '0;
      assign bank_wdata_o[k][j] = cl_wr ? refill_i.data[k*WORD_WIDTH +: WORD_WIDTH] :
                                          word_wr_i.data;
    end
  end

  always_comb begin : p_bank_req
    bank_req_o = '0;
    bank_we_o  = '0;
    bank_idx_o = {NUM_BANKS{word_wr_i.idx}};

    if (wr_cl_vld_i) begin
      // whole line goes into all banks at once
      bank_req_o = '1;
      bank_we_o  = '1;
      bank_idx_o = {NUM_BANKS{refill_i.idx}};
    end else begin
      if (rd_data) begin
        bank_req_o[gnt_addr.off] = 1'b1;
        bank_idx_o[gnt_addr.off] = gnt_addr.idx;
      end
      if (wr_ack_o) begin
        bank_req_o[word_wr_i.off] = 1'b1;
        bank_we_o[word_wr_i.off]  = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // tag array access
  ////////////////////////////////////////////////////////////////////////////

  // reads look up every way, refills write only the selected ones
  assign tag_we_o  = wr_cl_vld_i;
  assign tag_req_o = wr_cl_vld_i ? refill_i.we : {NUM_WAYS{rd_acked_i}};
  assign tag_idx_o = wr_cl_vld_i ? refill_i.idx : gnt_addr.idx;

endmodule

// ==== verilog/dcache_rd_arbiter.sv ====
// read port arbiter with priority masking and round-robin grant
module dcache_rd_arbiter #(
  parameter int unsigned  NumPorts = 3,
  localparam int unsigned IdxW     = (NumPorts > 1) ? $clog2(NumPorts) : 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [NumPorts-1:0] rd_req_i,
  input  logic [NumPorts-1:0] rd_prio_i,
  input  logic                wr_cl_vld_i,
  output logic [NumPorts-1:0] rd_ack_o,
  output logic                rd_acked_o,
  output logic [IdxW-1:0]     gnt_idx_o
);

  logic [NumPorts-1:0] req_prio;
  logic [NumPorts-1:0] req_masked;
  logic [IdxW-1:0]     rr_q;
  logic                found;

  // high prio requests hide all low prio ones
  assign req_prio   = rd_req_i & rd_prio_i;
  assign req_masked = (|req_prio) ? req_prio : rd_req_i;

  // first requester at or after the pointer
  always_comb begin : p_rr_pick
    int unsigned cand;
    found     = 1'b0;
    gnt_idx_o = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      cand = (rr_q + i) % NumPorts;
      if (!found && req_masked[cand]) begin
        found     = 1'b1;
        gnt_idx_o = IdxW'(cand);
      end
    end
  end

  // refill owns the arrays for its cycle
  assign rd_acked_o = found & ~wr_cl_vld_i;
  assign rd_ack_o   = rd_acked_o ? (NumPorts'(1) << gnt_idx_o) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_rr_ptr
    if (!rst_ni) begin
      rr_q <= '0;
    end else if (rd_acked_o) begin
      if (gnt_idx_o == IdxW'(NumPorts - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= gnt_idx_o + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/dcache_pkg.sv ====
// geometry constants, width typedefs and packed port structs of the dcache memory
package dcache_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_WAYS   = 4;
  localparam int unsigned NUM_SETS   = 64;
  localparam int unsigned WORD_WIDTH = 64;
  localparam int unsigned LINE_WIDTH = 256;
  // one bank per word offset
  localparam int unsigned NUM_BANKS  = LINE_WIDTH / WORD_WIDTH;
  localparam int unsigned TAG_WIDTH  = 20;

  localparam int unsigned WORD_BYTES = WORD_WIDTH / 8;
  localparam int unsigned IDX_WIDTH  = $clog2(NUM_SETS);
  localparam int unsigned OFF_WIDTH  = $clog2(NUM_BANKS);

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [WORD_WIDTH-1:0]   word_t;
  typedef logic [WORD_BYTES-1:0]   word_be_t;
  typedef logic [LINE_WIDTH-1:0]   line_t;
  typedef logic [LINE_WIDTH/8-1:0] line_be_t;
  typedef logic [TAG_WIDTH-1:0]    tag_t;
  typedef logic [IDX_WIDTH-1:0]    set_idx_t;
  typedef logic [OFF_WIDTH-1:0]    bank_sel_t;
  typedef logic [NUM_WAYS-1:0]     way_vec_t;
  typedef logic [NUM_BANKS-1:0]    bank_vec_t;

  ////////////////////////////////////////////////////////////////////////////
  // port structs
  ////////////////////////////////////////////////////////////////////////////

  // read port address whose tag follows one cycle later
  typedef struct packed {
    set_idx_t  idx;
    bank_sel_t off;
  } rd_addr_t;

  // full-line refill written in a single cycle
  typedef struct packed {
    way_vec_t we;
    tag_t     tag;
    set_idx_t idx;
    line_t    data;
    line_be_t be;
    way_vec_t vld_bits;
  } refill_t;

  // single-word write without tag access
  typedef struct packed {
    set_idx_t  idx;
    bank_sel_t off;
    word_t     data;
    word_be_t  be;
  } word_wr_t;

endpackage
